//--- hdl/cache_cfg_pkg.sv
// FIFO_DEPTH must be a power of two and PROG_THRESH must not exceed it
package cache_cfg_pkg;

  // ------------------------------------------------------------------
  // Cache front-end port
  // ------------------------------------------------------------------
  // Word and byte addresses share one width
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  // Byte address to word address
  localparam int BYTE_SHIFT = 2;

  // Issue FSM encoding
  localparam int                       ISSUE_STATE_W = 1;
  localparam logic [ISSUE_STATE_W-1:0] ISSUE_RESET   = 1'b0;
  localparam logic [ISSUE_STATE_W-1:0] ISSUE_READY   = 1'b1;

  // ------------------------------------------------------------------
  // FIFO sizing
  // ------------------------------------------------------------------
  localparam int FIFO_DEPTH  = 64;
  localparam int PROG_THRESH = 32;

endpackage

//--- hdl/mem_packet_pkg.sv
// Queued entries are packed MSB first as {cmd, id, addr, wdata} and {cmd, id, data}
package mem_packet_pkg;

  // ------------------------------------------------------------------
  // Memory packet fields
  // ------------------------------------------------------------------
  localparam int               CMD_W         = 2;
  localparam logic [CMD_W-1:0] CMD_MEM_READ  = 2'd1;
  localparam logic [CMD_W-1:0] CMD_MEM_WRITE = 2'd2;
  // Request tag, echoed in the response
  localparam int               ID_W          = 8;
  // Word offset from the descriptor base
  localparam int               OFFSET_W      = 16;

  // Request entry layout
  localparam int REQ_DATA_LSB = 0;
  localparam int REQ_ADDR_LSB = REQ_DATA_LSB + cache_cfg_pkg::DATA_W;
  localparam int REQ_ID_LSB   = REQ_ADDR_LSB + cache_cfg_pkg::ADDR_W;
  localparam int REQ_CMD_LSB  = REQ_ID_LSB + ID_W;
  localparam int REQ_W        = REQ_CMD_LSB + CMD_W;

  // Response entry layout
  localparam int RESP_DATA_LSB = 0;
  localparam int RESP_ID_LSB   = RESP_DATA_LSB + cache_cfg_pkg::DATA_W;
  localparam int RESP_CMD_LSB  = RESP_ID_LSB + ID_W;
  localparam int RESP_W        = RESP_CMD_LSB + CMD_W;

endpackage

//--- hdl/sync_fifo.sv
// DEPTH must be a power of two and a write into a full FIFO is dropped unless a read frees a slot
module sync_fifo #(
  parameter int WIDTH  = 8,
  parameter int DEPTH  = 64,
  parameter int THRESH = 32
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             empty_o,
  output logic             prog_full_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ------------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------------
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy, one wider than the pointers
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  // Pop only a real entry
  assign do_rd   = rd_en_i & ~empty_o;
  // Full is fine when the same cycle pops
  assign do_wr   = wr_en_i & (~full | do_rd);

  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------------
  // First word falls through
  assign dout_o      = mem[rd_ptr];
  assign prog_full_o = (count >= CNT_W'(THRESH));

endmodule

//--- hdl/request_ingress.sv
// Requests have no back-pressure and the base used is the one latched when stage two fires
module request_ingress (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                descriptor_valid_i,
  input  logic [cache_cfg_pkg::ADDR_W-1:0]    descriptor_base_i,
  input  logic                                request_valid_i,
  input  logic [mem_packet_pkg::CMD_W-1:0]    request_cmd_i,
  input  logic [mem_packet_pkg::ID_W-1:0]     request_id_i,
  input  logic [mem_packet_pkg::OFFSET_W-1:0] request_offset_i,
  input  logic [cache_cfg_pkg::DATA_W-1:0]    request_wdata_i,
  output logic                                push_o,
  output logic [mem_packet_pkg::REQ_W-1:0]    push_entry_o,
  output logic                                descriptor_valid_o
);

  // ------------------------------------------------------------------
  // Descriptor latch
  // ------------------------------------------------------------------
  logic [cache_cfg_pkg::ADDR_W-1:0] descriptor_base_q;

  // Valid sticks until reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_valid_o <= 1'b0;
    end else if (descriptor_valid_i) begin
      descriptor_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (descriptor_valid_i) begin
      descriptor_base_q <= descriptor_base_i;
    end
  end

  // ------------------------------------------------------------------
  // Stage one request register
  // ------------------------------------------------------------------
  logic                                request_valid_q;
  logic [mem_packet_pkg::CMD_W-1:0]    request_cmd_q;
  logic [mem_packet_pkg::ID_W-1:0]     request_id_q;
  logic [mem_packet_pkg::OFFSET_W-1:0] request_offset_q;
  logic [cache_cfg_pkg::DATA_W-1:0]    request_wdata_q;
  logic [cache_cfg_pkg::ADDR_W-1:0]    word_addr;
  logic [mem_packet_pkg::REQ_W-1:0]    entry_d;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_valid_q <= 1'b0;
      push_o          <= 1'b0;
    end else begin
      request_valid_q <= request_valid_i;
      // Stage two strobe is the FIFO write
      push_o          <= request_valid_q;
    end
  end

  always_ff @(posedge ap_clk) begin
    request_cmd_q    <= request_cmd_i;
    request_id_q     <= request_id_i;
    request_offset_q <= request_offset_i;
    request_wdata_q  <= request_wdata_i;
  end

  // ------------------------------------------------------------------
  // Stage two translation and packing
  // ------------------------------------------------------------------
  // Word base plus zero-extended offset
  assign word_addr = (descriptor_base_q >> cache_cfg_pkg::BYTE_SHIFT)
                   + {{(cache_cfg_pkg::ADDR_W - mem_packet_pkg::OFFSET_W){1'b0}},
                      request_offset_q};

  always_comb begin
    entry_d = '0;
    entry_d[mem_packet_pkg::REQ_CMD_LSB +: mem_packet_pkg::CMD_W]  = request_cmd_q;
    entry_d[mem_packet_pkg::REQ_ID_LSB +: mem_packet_pkg::ID_W]    = request_id_q;
    entry_d[mem_packet_pkg::REQ_ADDR_LSB +: cache_cfg_pkg::ADDR_W] = word_addr;
    entry_d[mem_packet_pkg::REQ_DATA_LSB +: cache_cfg_pkg::DATA_W] = request_wdata_q;
  end

  // Payload only
  always_ff @(posedge ap_clk) begin
    push_entry_o <= entry_d;
  end

endmodule

//--- hdl/cache_command_issue.sv
// One command in flight at a time and a head with neither read nor write code stalls the queue
module cache_command_issue (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  logic                             head_valid_i,
  input  logic [mem_packet_pkg::REQ_W-1:0] head_entry_i,
  input  logic                             resp_prog_full_i,
  input  logic                             descriptor_valid_i,
  input  logic                             cache_ready_i,
  input  logic                             cache_rvalid_i,
  output logic                             req_pop_o,
  output logic                             resp_push_o,
  output logic                             cache_valid_o,
  output logic [cache_cfg_pkg::ADDR_W-1:0] cache_addr_o,
  output logic [cache_cfg_pkg::DATA_W-1:0] cache_wdata_o,
  output logic [cache_cfg_pkg::STRB_W-1:0] cache_wstrb_o
);

  // ------------------------------------------------------------------
  // Head decode and issue gating
  // ------------------------------------------------------------------
  logic [cache_cfg_pkg::ISSUE_STATE_W-1:0] state_q;
  logic [cache_cfg_pkg::ISSUE_STATE_W-1:0] state_d;
  logic [mem_packet_pkg::CMD_W-1:0]        head_cmd;
  logic                                    head_is_read;
  logic                                    head_is_write;
  logic                                    issue_ok;

  assign head_cmd      = head_entry_i[mem_packet_pkg::REQ_CMD_LSB +: mem_packet_pkg::CMD_W];
  assign head_is_read  = (head_cmd == mem_packet_pkg::CMD_MEM_READ);
  assign head_is_write = (head_cmd == mem_packet_pkg::CMD_MEM_WRITE);

  // Head present, response room, descriptor loaded, cache ready
  assign issue_ok = head_valid_i & ~resp_prog_full_i & descriptor_valid_i & cache_ready_i;

  // ------------------------------------------------------------------
  // State register
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= cache_cfg_pkg::ISSUE_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Reset state lasts one cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_cfg_pkg::ISSUE_RESET: state_d = cache_cfg_pkg::ISSUE_READY;
      cache_cfg_pkg::ISSUE_READY: state_d = cache_cfg_pkg::ISSUE_READY;
      default:                    state_d = cache_cfg_pkg::ISSUE_RESET;
    endcase
  end

  // ------------------------------------------------------------------
  // Command and FIFO strobes
  // ------------------------------------------------------------------
  always_comb begin
    cache_valid_o = 1'b0;
    req_pop_o     = 1'b0;
    resp_push_o   = 1'b0;
    if (state_q == cache_cfg_pkg::ISSUE_READY && issue_ok) begin
      if (head_is_read) begin
        // Hold the read until data returns
        if (cache_rvalid_i) begin
          req_pop_o   = 1'b1;
          resp_push_o = 1'b1;
        end else begin
          cache_valid_o = 1'b1;
        end
      end else if (head_is_write) begin
        // Write completes on acceptance
        cache_valid_o = 1'b1;
        req_pop_o     = 1'b1;
        resp_push_o   = 1'b1;
      end
    end
  end

  // Command fields straight from the head
  assign cache_addr_o  = head_entry_i[mem_packet_pkg::REQ_ADDR_LSB +: cache_cfg_pkg::ADDR_W];
  assign cache_wdata_o = head_entry_i[mem_packet_pkg::REQ_DATA_LSB +: cache_cfg_pkg::DATA_W];
  // Reads carry zero strobes
  assign cache_wstrb_o = {cache_cfg_pkg::STRB_W{head_is_write}};

endmodule

//--- hdl/cu_cache_wrapper.sv
// Source keeps at most FIFO_DEPTH requests outstanding and response data is zero for writes
module cu_cache_wrapper (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                descriptor_valid_i,
  input  logic [cache_cfg_pkg::ADDR_W-1:0]    descriptor_base_i,
  input  logic                                request_valid_i,
  input  logic [mem_packet_pkg::CMD_W-1:0]    request_cmd_i,
  input  logic [mem_packet_pkg::ID_W-1:0]     request_id_i,
  input  logic [mem_packet_pkg::OFFSET_W-1:0] request_offset_i,
  input  logic [cache_cfg_pkg::DATA_W-1:0]    request_wdata_i,
  input  logic                                response_rd_en_i,
  output logic                                response_valid_o,
  output logic [mem_packet_pkg::CMD_W-1:0]    response_cmd_o,
  output logic [mem_packet_pkg::ID_W-1:0]     response_id_o,
  output logic [cache_cfg_pkg::DATA_W-1:0]    response_data_o,
  output logic                                cache_valid_o,
  output logic [cache_cfg_pkg::ADDR_W-1:0]    cache_addr_o,
  output logic [cache_cfg_pkg::DATA_W-1:0]    cache_wdata_o,
  output logic [cache_cfg_pkg::STRB_W-1:0]    cache_wstrb_o,
  input  logic                                cache_ready_i,
  input  logic                                cache_rvalid_i,
  input  logic [cache_cfg_pkg::DATA_W-1:0]    cache_rdata_i,
  input  logic                                cache_wtb_empty_i,
  output logic                                done_o
);

  // ------------------------------------------------------------------
  // Internal signals
  // ------------------------------------------------------------------
  logic                              req_push;
  logic [mem_packet_pkg::REQ_W-1:0]  req_entry;
  logic [mem_packet_pkg::REQ_W-1:0]  req_head;
  logic                              req_empty;
  logic                              req_pop;
  logic                              descriptor_valid;
  logic [mem_packet_pkg::CMD_W-1:0]  head_cmd;
  logic                              resp_push;
  logic [mem_packet_pkg::RESP_W-1:0] resp_din;
  logic [mem_packet_pkg::RESP_W-1:0] resp_dout;
  logic                              resp_empty;
  logic                              resp_prog_full;
  logic                              resp_rd_en_q;
  logic                              resp_pop;
  logic                              fifo_empty_int;
  logic                              fifo_empty_q;

  // Ingress stages
  request_ingress request_ingress_i (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .descriptor_valid_i (descriptor_valid_i),
    .descriptor_base_i  (descriptor_base_i),
    .request_valid_i    (request_valid_i),
    .request_cmd_i      (request_cmd_i),
    .request_id_i       (request_id_i),
    .request_offset_i   (request_offset_i),
    .request_wdata_i    (request_wdata_i),
    .push_o             (req_push),
    .push_entry_o       (req_entry),
    .descriptor_valid_o (descriptor_valid)
  );

  // Translated requests, head read directly
  sync_fifo #(
    .WIDTH  (mem_packet_pkg::REQ_W),
    .DEPTH  (cache_cfg_pkg::FIFO_DEPTH),
    .THRESH (cache_cfg_pkg::PROG_THRESH)
  ) request_fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (req_push),
    .din_i          (req_entry),
    .rd_en_i        (req_pop),
    .dout_o         (req_head),
    .empty_o        (req_empty),
    .prog_full_o    ()
  );

  cache_command_issue cache_command_issue_i (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .head_valid_i       (~req_empty),
    .head_entry_i       (req_head),
    .resp_prog_full_i   (resp_prog_full),
    .descriptor_valid_i (descriptor_valid),
    .cache_ready_i      (cache_ready_i),
    .cache_rvalid_i     (cache_rvalid_i),
    .req_pop_o          (req_pop),
    .resp_push_o        (resp_push),
    .cache_valid_o      (cache_valid_o),
    .cache_addr_o       (cache_addr_o),
    .cache_wdata_o      (cache_wdata_o),
    .cache_wstrb_o      (cache_wstrb_o)
  );

  // ------------------------------------------------------------------
  // Response entry and FIFO
  // ------------------------------------------------------------------
  assign head_cmd = req_head[mem_packet_pkg::REQ_CMD_LSB +: mem_packet_pkg::CMD_W];

  // Tag and command from the head being retired
  always_comb begin
    resp_din = '0;
    resp_din[mem_packet_pkg::RESP_CMD_LSB +: mem_packet_pkg::CMD_W] = head_cmd;
    resp_din[mem_packet_pkg::RESP_ID_LSB +: mem_packet_pkg::ID_W] =
      req_head[mem_packet_pkg::REQ_ID_LSB +: mem_packet_pkg::ID_W];
    if (head_cmd == mem_packet_pkg::CMD_MEM_READ) begin
      resp_din[mem_packet_pkg::RESP_DATA_LSB +: cache_cfg_pkg::DATA_W] = cache_rdata_i;
    end
  end

  sync_fifo #(
    .WIDTH  (mem_packet_pkg::RESP_W),
    .DEPTH  (cache_cfg_pkg::FIFO_DEPTH),
    .THRESH (cache_cfg_pkg::PROG_THRESH)
  ) response_fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (resp_push),
    .din_i          (resp_din),
    .rd_en_i        (resp_pop),
    .dout_o         (resp_dout),
    .empty_o        (resp_empty),
    .prog_full_o    (resp_prog_full)
  );

  // Registered enable gated by emptiness
  assign resp_pop = resp_rd_en_q & ~resp_empty;

  // ------------------------------------------------------------------
  // Output registers and done
  // ------------------------------------------------------------------
  // Both FIFOs drained, write buffer flushed, cache idle
  assign fifo_empty_int = req_empty & resp_empty & cache_wtb_empty_i & cache_ready_i;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_rd_en_q     <= 1'b0;
      response_valid_o <= 1'b0;
      fifo_empty_q     <= 1'b0;
      done_o           <= 1'b0;
    end else begin
      resp_rd_en_q     <= response_rd_en_i;
      response_valid_o <= resp_pop;
      fifo_empty_q     <= fifo_empty_int;
      done_o           <= fifo_empty_q;
    end
  end

  // Popped head captured for one-cycle presentation
  always_ff @(posedge ap_clk) begin
    if (resp_pop) begin
      response_cmd_o  <= resp_dout[mem_packet_pkg::RESP_CMD_LSB +: mem_packet_pkg::CMD_W];
      response_id_o   <= resp_dout[mem_packet_pkg::RESP_ID_LSB +: mem_packet_pkg::ID_W];
      response_data_o <= resp_dout[mem_packet_pkg::RESP_DATA_LSB +: cache_cfg_pkg::DATA_W];
    end
  end

endmodule

//--- sim/cache_model.sv
// Memory aliases on the low 10 word-address bits, one command at a time, reads return after 3 cycles
module cache_model (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  logic                             cache_valid_i,
  input  logic [cache_cfg_pkg::ADDR_W-1:0] cache_addr_i,
  input  logic [cache_cfg_pkg::DATA_W-1:0] cache_wdata_i,
  input  logic [cache_cfg_pkg::STRB_W-1:0] cache_wstrb_i,
  input  logic                             stall_i,
  input  logic                             wtb_hold_i,
  output logic                             cache_ready_o,
  output logic                             cache_rvalid_o,
  output logic [cache_cfg_pkg::DATA_W-1:0] cache_rdata_o,
  output logic                             cache_wtb_empty_o
);

  localparam int MEM_AW    = 10;
  localparam int READ_LAT  = 3;
  localparam int WTB_DRAIN = 3;

  logic [cache_cfg_pkg::DATA_W-1:0] mem [2**MEM_AW];
  logic [MEM_AW-1:0]                idx;
  logic                             busy;
  logic                             accept;
  logic                             is_write;
  logic [1:0]                       lat_cnt;
  logic [1:0]                       wtb_cnt;

  // ------------------------------------------------------------------
  // Port handshake
  // ------------------------------------------------------------------
  assign cache_ready_o = ~stall_i;
  assign idx           = cache_addr_i[MEM_AW-1:0];
  assign is_write      = |cache_wstrb_i;
  // A pending read blocks new commands until its data is taken
  assign accept        = cache_valid_i & cache_ready_o & ~busy;
  // Write buffer drains a few cycles after each write
  assign cache_wtb_empty_o = (wtb_cnt == 2'd0) & ~wtb_hold_i;

  // Fill tagged with the full word index
  initial begin
    for (int i = 0; i < 2**MEM_AW; i++) begin
      mem[i] = 32'hC0DE_0000 | i;
    end
  end

  always @(posedge ap_clk) begin
    if (accept && is_write) begin
      for (int b = 0; b < cache_cfg_pkg::STRB_W; b++) begin
        if (cache_wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= cache_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Read latency and write buffer
  // ------------------------------------------------------------------
  always @(posedge ap_clk) begin
    if (areset_control) begin
      busy           <= 1'b0;
      lat_cnt        <= 2'd0;
      wtb_cnt        <= 2'd0;
      cache_rvalid_o <= 1'b0;
      cache_rdata_o  <= '0;
    end else begin
      if (wtb_cnt != 2'd0) begin
        wtb_cnt <= wtb_cnt - 2'd1;
      end
      if (accept && is_write) begin
        wtb_cnt <= 2'(WTB_DRAIN);
      end
      if (accept && !is_write) begin
        busy          <= 1'b1;
        lat_cnt       <= 2'(READ_LAT - 1);
        cache_rdata_o <= mem[idx];
      end
      if (busy && !cache_rvalid_o) begin
        if (lat_cnt == 2'd0) begin
          cache_rvalid_o <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 2'd1;
        end
      end
      // Data held until the port is ready to take it
      if (cache_rvalid_o && cache_ready_o) begin
        cache_rvalid_o <= 1'b0;
        busy           <= 1'b0;
      end
    end
  end

endmodule

//--- sim/cu_cache_tb.sv
// Requests queued before the descriptor strobe carry an unknown base, so their address is not checked
module cu_cache_tb;

  localparam int          TIMEOUT_CYCLES  = 20000;
  localparam int          MAX_OUTSTANDING = 48;
  localparam logic [31:0] SEED            = 32'h65beac03;
  localparam logic [31:0] BASE            = 32'h0000_4400;

  logic        ap_clk;
  logic        areset_control;
  logic        descriptor_valid_i;
  logic [31:0] descriptor_base_i;
  logic        request_valid_i;
  logic [1:0]  request_cmd_i;
  logic [7:0]  request_id_i;
  logic [15:0] request_offset_i;
  logic [31:0] request_wdata_i;
  logic        response_rd_en_i;
  logic        response_valid_o;
  logic [1:0]  response_cmd_o;
  logic [7:0]  response_id_o;
  logic [31:0] response_data_o;
  logic        cache_valid_o;
  logic [31:0] cache_addr_o;
  logic [31:0] cache_wdata_o;
  logic [3:0]  cache_wstrb_o;
  logic        cache_ready_i;
  logic        cache_rvalid_i;
  logic [31:0] cache_rdata_i;
  logic        cache_wtb_empty_i;
  logic        done_o;
  logic        stall;
  logic        stall_next;
  logic        wtb_hold;

  // Expected commands and responses in request order
  logic [31:0] exp_addr_q [$];
  logic        exp_wr_q [$];
  logic [31:0] exp_wdata_q [$];
  logic        exp_chk_q [$];
  logic [1:0]  exp_rcmd_q [$];
  logic [7:0]  exp_rid_q [$];
  logic [31:0] exp_rdata_q [$];
  logic [31:0] ref_mem [256];
  logic [31:0] lfsr;
  logic [7:0]  next_id;
  logic        desc_sent;
  string       phase;
  int          sent;
  int          completed;
  int          received;
  int          low_cycles;
  int          cycles;
  int          value_errors;
  int          protocol_errors;

  cu_cache_wrapper cu_cache_wrapper_i (.*);

  cache_model cache_model_i (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .cache_valid_i     (cache_valid_o),
    .cache_addr_i      (cache_addr_o),
    .cache_wdata_i     (cache_wdata_o),
    .cache_wstrb_i     (cache_wstrb_o),
    .stall_i           (stall),
    .wtb_hold_i        (wtb_hold),
    .cache_ready_o     (cache_ready_i),
    .cache_rvalid_o    (cache_rvalid_i),
    .cache_rdata_o     (cache_rdata_i),
    .cache_wtb_empty_o (cache_wtb_empty_i)
  );

  always #2 ap_clk = ~ap_clk;

  // ------------------------------------------------------------------
  // Random bits and checks
  // ------------------------------------------------------------------
  // Galois right shift with taps for x^32+x^31+x^29+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      value_errors++;
      $display("FAIL %s %s: expected %0h, actual %0h", phase, what, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      protocol_errors++;
      $display("ERROR in %s: %s", phase, what);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d value, %0d protocol; %0d requests sent, %0d responses received",
             value_errors, protocol_errors, sent, received);
  endtask

  task automatic pop_command();
    void'(exp_addr_q.pop_front());
    void'(exp_wr_q.pop_front());
    void'(exp_wdata_q.pop_front());
    void'(exp_chk_q.pop_front());
    completed++;
  endtask

  // Cache stalls about one cycle in four
  always @(negedge ap_clk) begin : stall_gen
    logic [31:0] r;
    take_bits(2, r);
    stall_next = (r[1:0] == 2'b00);
  end

  // Stall level moves on the rising edge
  always @(posedge ap_clk) begin
    stall <= stall_next;
  end

  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Monitor sampled mid-cycle
  // ------------------------------------------------------------------
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      check_true(!(cache_valid_o && !desc_sent), "command issued before the descriptor");
      if (cache_valid_o && cache_ready_i) begin
        if (exp_addr_q.size() == 0) begin
          check_true(1'b0, "command issued with no request pending");
        end else begin
          if (exp_chk_q[0]) begin
            check_eq("cache address", exp_addr_q[0], cache_addr_o);
          end
          check_eq("write strobes", exp_wr_q[0] ? 4'hF : 4'h0, cache_wstrb_o);
          // Reads complete on returned data, writes on acceptance
          if (exp_wr_q[0]) begin
            check_eq("write data", exp_wdata_q[0], cache_wdata_o);
            pop_command();
          end
        end
      end
      if (cache_rvalid_i && cache_ready_i) begin
        if (exp_wr_q.size() == 0 || exp_wr_q[0]) begin
          check_true(1'b0, "read data returned with no read at the head");
        end else begin
          pop_command();
        end
      end
      if (response_valid_o) begin
        if (exp_rid_q.size() == 0) begin
          check_true(1'b0, "response with none expected");
        end else begin
          check_eq("response command", exp_rcmd_q.pop_front(), response_cmd_o);
          check_eq("response tag", exp_rid_q.pop_front(), response_id_o);
          check_eq("response data", exp_rdata_q.pop_front(), response_data_o);
          received++;
        end
      end
      // Two low cycles flush the registered read enable
      low_cycles = response_rd_en_i ? 0 : low_cycles + 1;
      if (low_cycles >= 2) begin
        check_true(completed - received <= cache_cfg_pkg::PROG_THRESH,
                   "response FIFO filled past the threshold");
      end
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  task automatic send_request(input logic is_wr, input logic [15:0] off,
                              input logic [31:0] wdata, input logic chk);
    while (sent - completed >= MAX_OUTSTANDING) begin
      @(posedge ap_clk);
      request_valid_i <= 1'b0;
    end
    @(posedge ap_clk);
    request_valid_i  <= 1'b1;
    request_cmd_i    <= is_wr ? mem_packet_pkg::CMD_MEM_WRITE : mem_packet_pkg::CMD_MEM_READ;
    request_id_i     <= next_id;
    request_offset_i <= off;
    request_wdata_i  <= wdata;
    exp_addr_q.push_back((BASE >> 2) + {16'h0000, off});
    exp_wr_q.push_back(is_wr);
    exp_wdata_q.push_back(wdata);
    exp_chk_q.push_back(chk);
    exp_rcmd_q.push_back(is_wr ? mem_packet_pkg::CMD_MEM_WRITE : mem_packet_pkg::CMD_MEM_READ);
    exp_rid_q.push_back(next_id);
    // Writes answer with zero, reads with the last value written
    exp_rdata_q.push_back(is_wr ? 32'h0 : ref_mem[off[7:0]]);
    if (is_wr && chk) begin
      ref_mem[off[7:0]] = wdata;
    end
    next_id++;
    sent++;
  endtask

  task automatic end_burst();
    @(posedge ap_clk);
    request_valid_i <= 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge ap_clk);
  endtask

  task automatic wait_responses();
    end_burst();
    while (exp_rid_q.size() != 0) begin
      @(posedge ap_clk);
    end
  endtask

  task automatic wait_done();
    while (!done_o) begin
      @(posedge ap_clk);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  offs [100];
    ap_clk             = 1'b0;
    areset_control     = 1'b1;
    descriptor_valid_i = 1'b0;
    descriptor_base_i  = '0;
    request_valid_i    = 1'b0;
    request_cmd_i      = '0;
    request_id_i       = '0;
    request_offset_i   = '0;
    request_wdata_i    = '0;
    response_rd_en_i   = 1'b1;
    stall              = 1'b0;
    stall_next         = 1'b0;
    wtb_hold           = 1'b0;
    lfsr               = SEED;
    next_id            = '0;
    desc_sent          = 1'b0;
    phase              = "reset";
    sent               = 0;
    completed          = 0;
    received           = 0;
    low_cycles         = 0;
    cycles             = 0;
    value_errors       = 0;
    protocol_errors    = 0;
    wait_cycles(2);
    areset_control <= 1'b0;
    @(negedge ap_clk);
    check_eq("cache valid", 0, cache_valid_o);
    check_eq("response valid", 0, response_valid_o);
    check_eq("done", 0, done_o);

    // Requests parked until the descriptor arrives
    phase = "no descriptor";
    for (int i = 0; i < 16; i++) begin
      send_request(1'b1, 16'h0200 + 16'(i), 32'hA000_0000 + i, 1'b0);
    end
    end_burst();
    wait_cycles(40);
    check_eq("commands before descriptor", 0, completed);
    @(posedge ap_clk);
    descriptor_valid_i <= 1'b1;
    descriptor_base_i  <= BASE;
    desc_sent = 1'b1;
    @(posedge ap_clk);
    descriptor_valid_i <= 1'b0;
    wait_responses();
    wait_done();

    phase = "write then read";
    for (int i = 0; i < 100; i++) begin
      take_bits(8, r);
      offs[i] = r[7:0];
      take_bits(32, r);
      send_request(1'b1, {8'h00, offs[i]}, r, 1'b1);
    end
    for (int i = 0; i < 100; i++) begin
      send_request(1'b0, {8'h00, offs[i]}, 32'h0, 1'b1);
    end
    wait_responses();
    wait_done();

    phase = "back-pressure";
    @(posedge ap_clk);
    response_rd_en_i <= 1'b0;
    for (int i = 0; i < 25; i++) begin
      take_bits(32, r);
      send_request(1'b1, {8'h00, offs[i]}, r, 1'b1);
      send_request(1'b0, {8'h00, offs[i]}, 32'h0, 1'b1);
    end
    end_burst();
    wait_cycles(400);
    check_eq("queued responses", cache_cfg_pkg::PROG_THRESH, completed - received);
    check_eq("done with requests pending", 0, done_o);
    @(posedge ap_clk);
    response_rd_en_i <= 1'b1;
    wait_responses();
    wait_done();

    phase = "write buffer";
    @(posedge ap_clk);
    wtb_hold <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      take_bits(32, r);
      send_request(1'b1, {8'h00, offs[50 + i]}, r, 1'b1);
      send_request(1'b0, {8'h00, offs[50 + i]}, 32'h0, 1'b1);
    end
    wait_responses();
    wait_cycles(10);
    check_eq("done with write buffer busy", 0, done_o);
    @(posedge ap_clk);
    wtb_hold <= 1'b0;
    wait_done();

    phase = "end";
    check_true(exp_addr_q.size() == 0, "requests left without a command");
    report_counts();
    if (value_errors + protocol_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- cu_cache.f
hdl/cache_cfg_pkg.sv
hdl/mem_packet_pkg.sv
hdl/sync_fifo.sv
hdl/request_ingress.sv
hdl/cache_command_issue.sv
hdl/cu_cache_wrapper.sv
sim/cache_model.sv
sim/cu_cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cu_cache_tb \
  -f cu_cache.f -o cu_cache_sim 2>&1 | tee build.log || { echo "Build failed"; exit 1; }
./obj_dir/cu_cache_sim 2>&1 | tee sim.log || { echo "Simulation aborted"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
